// ==== logic/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and address width
`define CPU_XLEN 32

// architectural register file
`define CPU_NUM_REGS 32
`define CPU_REG_ADDR_W 5

// first fetch address out of reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== logic/cpu_pkg.sv ====
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] wordT;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluOpT;

    // values match the branch funct3 field
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } branchCondT;

    typedef enum logic [1:0] {
        wbAlu,
        wbLink,
        wbUpper,
        wbLoad
    } wbSelT;

endpackage

// ==== logic/instr_decode.sv ====
`timescale 1ns/1ns
`include "cpu_settings.svh"

module instr_decode (
    input  cpu_pkg::wordT               instr,
    output cpu_pkg::opcodeT             opcode,
    output logic [`CPU_REG_ADDR_W-1:0]  rd,
    output logic [`CPU_REG_ADDR_W-1:0]  rs1,
    output logic [`CPU_REG_ADDR_W-1:0]  rs2,
    output cpu_pkg::wordT               imm,
    output cpu_pkg::aluOpT              aluOp,
    output logic                        aluUseImm,
    output cpu_pkg::branchCondT         branchCond,
    output cpu_pkg::wbSelT              wbSel,
    output logic                        regWen,
    output logic                        memWen,
    output logic                        illegal
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic funct7Zero;
    logic funct7Alt;                     // sub / sra form
    cpu_pkg::wordT immI;
    cpu_pkg::wordT immS;
    cpu_pkg::wordT immB;
    cpu_pkg::wordT immU;
    cpu_pkg::wordT immJ;
    cpu_pkg::aluOpT arithOp;

    assign opcode = cpu_pkg::opcodeT'(instr[6:0]);
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];        // also imm[11:5] for shift immediates

    assign funct7Zero = (funct7 == 7'b0000000);
    assign funct7Alt  = (funct7 == 7'b0100000);

    assign immI = {{(`CPU_XLEN-12){instr[31]}}, instr[31:20]};
    assign immS = {{(`CPU_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{(`CPU_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                   instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{(`CPU_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                   instr[30:21], 1'b0};

    // shared funct3 map for reg and imm arithmetic
    always_comb begin
        case (funct3)
            3'b000:  arithOp = (opcode == cpu_pkg::opReg && funct7[5]) ? cpu_pkg::aluSub
                                                                       : cpu_pkg::aluAdd;
            3'b001:  arithOp = cpu_pkg::aluSll;
            3'b010:  arithOp = cpu_pkg::aluSlt;
            3'b011:  arithOp = cpu_pkg::aluSltu;
            3'b100:  arithOp = cpu_pkg::aluXor;
            3'b101:  arithOp = funct7[5] ? cpu_pkg::aluSra : cpu_pkg::aluSrl;
            3'b110:  arithOp = cpu_pkg::aluOr;
            default: arithOp = cpu_pkg::aluAnd;
        endcase
    end

    always_comb begin
        imm        = immI;
        aluOp      = cpu_pkg::aluAdd;    // address and auipc sums
        aluUseImm  = 1'b0;
        branchCond = cpu_pkg::branchCondT'(funct3);
        wbSel      = cpu_pkg::wbAlu;
        regWen     = 1'b0;
        memWen     = 1'b0;
        illegal    = 1'b0;
        case (opcode)
            cpu_pkg::opLui: begin
                imm    = immU;
                wbSel  = cpu_pkg::wbUpper;
                regWen = 1'b1;
            end
            cpu_pkg::opAuipc: begin
                imm       = immU;
                aluUseImm = 1'b1;
                wbSel     = cpu_pkg::wbUpper;
                regWen    = 1'b1;
            end
            cpu_pkg::opJal: begin
                imm    = immJ;
                wbSel  = cpu_pkg::wbLink;
                regWen = 1'b1;
            end
            cpu_pkg::opJalr: begin
                wbSel   = cpu_pkg::wbLink;
                regWen  = 1'b1;
                illegal = (funct3 != 3'b000);
            end
            cpu_pkg::opBranch: begin
                imm     = immB;
                illegal = (funct3[2:1] == 2'b01);    // funct3 2 and 3 unused
            end
            cpu_pkg::opLoad: begin
                aluUseImm = 1'b1;
                wbSel     = cpu_pkg::wbLoad;
                regWen    = 1'b1;
                illegal   = (funct3 != 3'b010);      // lw only
            end
            cpu_pkg::opStore: begin
                imm       = immS;
                aluUseImm = 1'b1;
                memWen    = 1'b1;
                illegal   = (funct3 != 3'b010);      // sw only
            end
            cpu_pkg::opImm: begin
                aluOp     = arithOp;
                aluUseImm = 1'b1;
                regWen    = 1'b1;
                if (funct3 == 3'b001) begin
                    illegal = !funct7Zero;
                end else if (funct3 == 3'b101) begin
                    illegal = !(funct7Zero || funct7Alt);
                end
            end
            cpu_pkg::opReg: begin
                aluOp   = arithOp;
                regWen  = 1'b1;
                illegal = !(funct7Zero ||
                            (funct7Alt && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            default: illegal = 1'b1;
        endcase
        // no side effects from a bad encoding
        if (illegal) begin
            regWen = 1'b0;
            memWen = 1'b0;
        end
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns
`include "cpu_settings.svh"

module reg_file (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`CPU_REG_ADDR_W-1:0]  rs1,
    input  logic [`CPU_REG_ADDR_W-1:0]  rs2,
    output cpu_pkg::wordT               rs1Data,
    output cpu_pkg::wordT               rs2Data,
    input  logic [`CPU_REG_ADDR_W-1:0]  rd,
    input  logic                        wen,
    input  cpu_pkg::wordT               wdata
);

    cpu_pkg::wordT regs [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin    // x0 never written
            regs[rd] <= wdata;
        end
    end

    // async read, x0 reads zero
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ns
`include "cpu_settings.svh"

module alu (
    input  cpu_pkg::wordT   a,
    input  cpu_pkg::wordT   b,
    input  cpu_pkg::aluOpT  aluOp,
    output cpu_pkg::wordT   result
);

    logic [4:0] shamt;
    logic signedLess;
    logic unsignedLess;

    assign shamt = b[4:0];

    // compare results for slt and sltu
    assign signedLess   = ($signed(a) < $signed(b));
    assign unsignedLess = (a < b);

    always_comb begin
        case (aluOp)
            cpu_pkg::aluAdd:  result = a + b;       // also load/store address
            cpu_pkg::aluSub:  result = a - b;
            cpu_pkg::aluSll:  result = a << shamt;
            cpu_pkg::aluSlt:  result = {{(`CPU_XLEN-1){1'b0}}, signedLess};
            cpu_pkg::aluSltu: result = {{(`CPU_XLEN-1){1'b0}}, unsignedLess};
            cpu_pkg::aluXor:  result = a ^ b;
            cpu_pkg::aluSrl:  result = a >> shamt;
            cpu_pkg::aluSra:  result = $signed(a) >>> shamt;   // sign fill
            cpu_pkg::aluOr:   result = a | b;
            cpu_pkg::aluAnd:  result = a & b;
            default:          result = '0;
        endcase
    end

endmodule

// ==== logic/next_pc.sv ====
`timescale 1ns/1ns
`include "cpu_settings.svh"

module next_pc (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_pkg::opcodeT      opcode,
    input  cpu_pkg::branchCondT  branchCond,
    input  cpu_pkg::wordT        imm,
    input  cpu_pkg::wordT        rs1Data,
    input  cpu_pkg::wordT        rs2Data,
    input  logic                 illegal,
    output cpu_pkg::wordT        pc,
    output logic                 halt
);

    logic taken;
    cpu_pkg::wordT pcPlus4;
    cpu_pkg::wordT pcPlusImm;
    cpu_pkg::wordT jalrSum;
    cpu_pkg::wordT pcNext;

    always_comb begin
        case (branchCond)
            cpu_pkg::brEq:  taken = (rs1Data == rs2Data);
            cpu_pkg::brNe:  taken = (rs1Data != rs2Data);
            cpu_pkg::brLt:  taken = ($signed(rs1Data) < $signed(rs2Data));
            cpu_pkg::brGe:  taken = ($signed(rs1Data) >= $signed(rs2Data));
            cpu_pkg::brLtu: taken = (rs1Data < rs2Data);
            cpu_pkg::brGeu: taken = (rs1Data >= rs2Data);
            default:        taken = 1'b0;   // reserved, decode flags it
        endcase
    end

    assign pcPlus4   = pc + 32'd4;
    assign pcPlusImm = pc + imm;
    assign jalrSum   = rs1Data + imm;

    always_comb begin
        if (opcode == cpu_pkg::opJal || (opcode == cpu_pkg::opBranch && taken)) begin
            pcNext = pcPlusImm;
        end else if (opcode == cpu_pkg::opJalr) begin
            pcNext = {jalrSum[`CPU_XLEN-1:1], 1'b0};   // lsb dropped
        end else begin
            pcNext = pcPlus4;
        end
    end

    // halt is sticky until reset, pc holds on the bad instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            pc   <= `CPU_RESET_PC;
            halt <= 1'b0;
        end else if (!halt) begin
            if (illegal) halt <= 1'b1;
            else         pc   <= pcNext;
        end
    end

endmodule

// ==== logic/single_cycle_cpu.sv ====
`timescale 1ns/1ns
`include "cpu_settings.svh"

module single_cycle_cpu (
    input  logic           clk,
    input  logic           rst,
    output cpu_pkg::wordT  instrAddr,
    input  cpu_pkg::wordT  instr,
    output cpu_pkg::wordT  dataAddr,
    output cpu_pkg::wordT  dataWrite,
    output logic           dataWen,
    input  cpu_pkg::wordT  dataRead,
    output logic           halt
);

    cpu_pkg::opcodeT opcode;
    logic [`CPU_REG_ADDR_W-1:0] rd;
    logic [`CPU_REG_ADDR_W-1:0] rs1;
    logic [`CPU_REG_ADDR_W-1:0] rs2;
    cpu_pkg::wordT imm;
    cpu_pkg::aluOpT aluOp;
    logic aluUseImm;
    cpu_pkg::branchCondT branchCond;
    cpu_pkg::wbSelT wbSel;
    logic regWen;
    logic memWen;
    logic illegal;
    cpu_pkg::wordT rs1Data;
    cpu_pkg::wordT rs2Data;
    cpu_pkg::wordT aluA;
    cpu_pkg::wordT aluB;
    cpu_pkg::wordT aluResult;
    cpu_pkg::wordT wbData;
    cpu_pkg::wordT pc;

    instr_decode instr_decode_inst (
        .instr(instr), .opcode(opcode), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
        .aluOp(aluOp), .aluUseImm(aluUseImm), .branchCond(branchCond), .wbSel(wbSel),
        .regWen(regWen), .memWen(memWen), .illegal(illegal)
    );

    reg_file reg_file_inst (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .rd(rd), .wen(regWen && !halt), .wdata(wbData)
    );

    // auipc adds to the pc instead of rs1
    assign aluA = (opcode == cpu_pkg::opAuipc) ? pc : rs1Data;
    assign aluB = aluUseImm ? imm : rs2Data;

    alu alu_inst (.a(aluA), .b(aluB), .aluOp(aluOp), .result(aluResult));

    next_pc next_pc_inst (
        .clk(clk), .rst(rst), .opcode(opcode), .branchCond(branchCond), .imm(imm),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .illegal(illegal), .pc(pc), .halt(halt)
    );

    always_comb begin
        case (wbSel)
            cpu_pkg::wbAlu:   wbData = aluResult;
            cpu_pkg::wbLink:  wbData = pc + 32'd4;   // return address
            cpu_pkg::wbUpper: wbData = (opcode == cpu_pkg::opLui) ? imm : aluResult;
            default:          wbData = dataRead;
        endcase
    end

    assign instrAddr = pc;
    assign dataAddr  = aluResult;
    assign dataWrite = rs2Data;
    assign dataWen   = memWen && !halt;   // one strobe per sw

endmodule

// ==== tb/test_program.svh ====
function automatic cpu_pkg::wordT encR(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                       logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, cpu_pkg::opReg};
endfunction

function automatic cpu_pkg::wordT encI(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                       logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

// sw only, funct3 fixed
function automatic cpu_pkg::wordT encS(logic [4:0] rs2, logic [11:0] imm, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::opStore};
endfunction

function automatic cpu_pkg::wordT encB(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                       logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpu_pkg::opBranch};
endfunction

function automatic cpu_pkg::wordT encU(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, op};
endfunction

function automatic cpu_pkg::wordT encJ(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, cpu_pkg::opJal};
endfunction

task automatic emit(cpu_pkg::wordT w);
    rom[romTop] = w;
    poisonAt[romTop] = 1'b0;
    romTop++;
endtask

// sw to the next result slot off x10, remember what it must hold
task automatic storeResult(logic [4:0] r, cpu_pkg::wordT value);
    emit(encS(r, 12'(storeOff), 5'd10));
    expAddr.push_back(32'd64 + 32'(storeOff));
    expData.push_back(value);
    expTest.push_back(curGroup);
    storeOff += 4;
endtask

task automatic aluAndStore(cpu_pkg::wordT w, cpu_pkg::wordT value);
    emit(w);    // always targets x3
    storeResult(5'd3, value);
endtask

task automatic takenBranch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2);
    emit(encB(f3, rs1, rs2, 13'd8));
    romTop++;   // poison word jumped over
endtask

// target is the last ROM word, poison
task automatic fallBranch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2);
    emit(encB(f3, rs1, rs2, 13'(508 - 4 * romTop)));
endtask

task automatic buildProgram();
    int loadOff;
    int linkAddr;
    for (int i = 0; i < 128; i++) begin
        rom[i] = {i[24:0], 7'b0101101};    // unused opcode
        poisonAt[i] = 1'b1;
    end
    curGroup = 2;
    emit(encI(cpu_pkg::opLoad, 3'b010, 5'd1, 5'd0, 12'd0));    // x1 = opA
    emit(encI(cpu_pkg::opLoad, 3'b010, 5'd2, 5'd0, 12'd4));    // x2 = opB
    emit(encI(cpu_pkg::opImm, 3'b000, 5'd10, 5'd0, 12'd64));   // result area
    aluAndStore(encR(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), opA + opB);
    aluAndStore(encR(7'h20, 3'b000, 5'd3, 5'd1, 5'd2), opA - opB);
    aluAndStore(encR(7'h00, 3'b001, 5'd3, 5'd1, 5'd2), opA << opB[4:0]);
    aluAndStore(encR(7'h00, 3'b010, 5'd3, 5'd1, 5'd2), 32'($signed(opA) < $signed(opB)));
    aluAndStore(encR(7'h00, 3'b011, 5'd3, 5'd1, 5'd2), 32'(opA < opB));
    aluAndStore(encR(7'h00, 3'b100, 5'd3, 5'd1, 5'd2), opA ^ opB);
    aluAndStore(encR(7'h00, 3'b101, 5'd3, 5'd1, 5'd2), opA >> opB[4:0]);
    aluAndStore(encR(7'h20, 3'b101, 5'd3, 5'd1, 5'd2), $signed(opA) >>> opB[4:0]);
    aluAndStore(encR(7'h00, 3'b110, 5'd3, 5'd1, 5'd2), opA | opB);
    aluAndStore(encR(7'h00, 3'b111, 5'd3, 5'd1, 5'd2), opA & opB);
    aluAndStore(encI(cpu_pkg::opImm, 3'b000, 5'd3, 5'd1, 12'hFFB), opA - 32'd5);
    aluAndStore(encI(cpu_pkg::opImm, 3'b010, 5'd3, 5'd1, 12'd100),
                32'($signed(opA) < 32'sd100));
    aluAndStore(encI(cpu_pkg::opImm, 3'b011, 5'd3, 5'd1, 12'hFFF), 32'(opA < 32'hFFFF_FFFF));
    aluAndStore(encI(cpu_pkg::opImm, 3'b100, 5'd3, 5'd1, 12'h555), opA ^ 32'h555);
    aluAndStore(encI(cpu_pkg::opImm, 3'b110, 5'd3, 5'd1, 12'hF00), opA | 32'hFFFF_FF00);
    aluAndStore(encI(cpu_pkg::opImm, 3'b111, 5'd3, 5'd1, 12'h7F0), opA & 32'h7F0);
    aluAndStore(encI(cpu_pkg::opImm, 3'b001, 5'd3, 5'd1, 12'h007), opA << 7);
    aluAndStore(encI(cpu_pkg::opImm, 3'b101, 5'd3, 5'd1, 12'h009), opA >> 9);
    aluAndStore(encI(cpu_pkg::opImm, 3'b101, 5'd3, 5'd1, 12'h40D), $signed(opA) >>> 13);
    curGroup = 3;
    aluAndStore(encU(cpu_pkg::opLui, 5'd3, 20'hABCDE), 32'hABCD_E000);
    aluAndStore(encU(cpu_pkg::opAuipc, 5'd3, 20'h12345), 32'(4 * romTop) + 32'h1234_5000);
    loadOff = storeOff;
    storeResult(5'd2, opB);
    emit(encI(cpu_pkg::opLoad, 3'b010, 5'd4, 5'd10, 12'(loadOff)));    // read it back
    aluAndStore(encI(cpu_pkg::opImm, 3'b000, 5'd3, 5'd4, 12'd1), opB + 32'd1);
    curGroup = 4;
    emit(encI(cpu_pkg::opImm, 3'b000, 5'd6, 5'd0, 12'd5));     // loop bound
    emit(encI(cpu_pkg::opImm, 3'b000, 5'd5, 5'd5, 12'd1));
    emit(encB(3'b100, 5'd5, 5'd6, 13'h1FFC));                  // blt back one word
    storeResult(5'd5, 32'd5);
    emit(encI(cpu_pkg::opImm, 3'b000, 5'd7, 5'd0, 12'hFFF));   // x7 = -1
    emit(encI(cpu_pkg::opImm, 3'b000, 5'd8, 5'd0, 12'd1));     // x8 = 1
    takenBranch(3'b000, 5'd8, 5'd8);
    fallBranch(3'b000, 5'd7, 5'd8);
    takenBranch(3'b001, 5'd7, 5'd8);
    fallBranch(3'b001, 5'd8, 5'd8);
    takenBranch(3'b100, 5'd7, 5'd8);
    fallBranch(3'b100, 5'd8, 5'd7);
    takenBranch(3'b101, 5'd8, 5'd7);
    fallBranch(3'b101, 5'd7, 5'd8);
    takenBranch(3'b110, 5'd8, 5'd7);    // 1 below 0xffffffff unsigned
    fallBranch(3'b110, 5'd7, 5'd8);
    takenBranch(3'b111, 5'd7, 5'd8);
    fallBranch(3'b111, 5'd8, 5'd7);
    linkAddr = 4 * romTop + 4;
    emit(encJ(5'd11, 21'd8));
    romTop++;
    storeResult(5'd11, 32'(linkAddr));
    linkAddr = 4 * romTop + 8;
    emit(encU(cpu_pkg::opAuipc, 5'd12, 20'h0));
    emit(encI(cpu_pkg::opJalr, 3'b000, 5'd13, 5'd12, 12'd12));
    romTop++;
    storeResult(5'd13, 32'(linkAddr));
    haltAddr = 32'(4 * romTop);
    emit(encI(cpu_pkg::opLoad, 3'b001, 5'd3, 5'd0, 12'd0));    // lh, not supported
endtask

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpu_tb;

    logic clk = 1'b0;
    logic rst = 1'b1;
    cpu_pkg::wordT instrAddr;
    cpu_pkg::wordT instr;
    cpu_pkg::wordT dataAddr;
    cpu_pkg::wordT dataWrite;
    logic dataWen;
    cpu_pkg::wordT dataRead;
    logic halt;

    cpu_pkg::wordT rom [128];
    logic poisonAt [128];           // words a correct core never fetches
    cpu_pkg::wordT dmem [64];
    cpu_pkg::wordT opA;
    cpu_pkg::wordT opB;
    cpu_pkg::wordT haltAddr;
    cpu_pkg::wordT expAddr [$];
    cpu_pkg::wordT expData [$];
    int expTest [$];                // test each store belongs to
    int romTop = 0;
    int storeOff = 0;
    int curGroup = 2;
    int storeIdx = 0;
    int errCount = 0;
    int testsFailed = 0;
    int testErrs [1:5] = '{default: 0};
    bit testDone [1:5] = '{default: 1'b0};
    string testName [1:5] = '{"reset", "arithmetic", "upper and memory", "control flow",
                              "halt"};

    `include "test_program.svh"

    single_cycle_cpu single_cycle_cpu_inst (
        .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr), .dataAddr(dataAddr),
        .dataWrite(dataWrite), .dataWen(dataWen), .dataRead(dataRead), .halt(halt)
    );

    always #10 clk = ~clk;

    assign instr    = rom[instrAddr[8:2]];
    assign dataRead = dmem[dataAddr[7:2]];

    // preload during reset with the operands in words 0 and 1
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= {16'hC0DE, i[15:0]};
            end
            dmem[0] <= opA;
            dmem[1] <= opB;
        end else if (dataWen) begin
            dmem[dataAddr[7:2]] <= dataWrite;
        end
    end

    function automatic int currentTest();
        return (storeIdx < expTest.size()) ? expTest[storeIdx] : 5;
    endfunction

    task automatic noteError(int t);
        errCount++;
        testErrs[t]++;
    endtask

    task automatic reportTest(int t);
        testDone[t] = 1'b1;
        if (testErrs[t] != 0) testsFailed++;
        $display("test %0d %s: %0d errors", t, testName[t], testErrs[t]);
    endtask

    task automatic checkStore();
        int t;
        t = currentTest();
        if (storeIdx >= expAddr.size()) begin
            $display("time %0t: unexpected store of 0x%08h to 0x%08h", $time, dataWrite,
                     dataAddr);
            noteError(t);
        end else begin
            assert (dataAddr == expAddr[storeIdx]) else begin
                $display("MISMATCH time %0t dataAddr expected 0x%08h actual 0x%08h", $time,
                         expAddr[storeIdx], dataAddr);
                noteError(t);
            end
            assert (dataWrite == expData[storeIdx]) else begin
                $display("MISMATCH time %0t dataWrite expected 0x%08h actual 0x%08h", $time,
                         expData[storeIdx], dataWrite);
                noteError(t);
            end
            // last store of its group closes the test
            if (storeIdx + 1 == expAddr.size() || expTest[storeIdx + 1] != t) reportTest(t);
        end
        storeIdx++;
    endtask

    // sample mid-cycle once outputs have settled
    task automatic nextCycle();
        @(negedge clk);
        if (!rst) begin
            assert (!poisonAt[instrAddr[8:2]]) else begin
                $display("time %0t: fetch reached the poison word at 0x%08h", $time, instrAddr);
                noteError(currentTest());
            end
            if (dataWen) checkStore();
        end
    endtask

    initial begin
        int cycles;
        void'($urandom(77));
        // opA negative and opB not, so signed and unsigned results differ
        opA = $urandom() | 32'h8000_0000;
        opB = $urandom() & 32'h7FFF_FFFF;
        buildProgram();
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        nextCycle();
        assert (instrAddr == `CPU_RESET_PC) else begin
            $display("MISMATCH time %0t instrAddr expected 0x%08h actual 0x%08h", $time,
                     `CPU_RESET_PC, instrAddr);
            noteError(1);
        end
        assert (!halt) else begin
            $display("MISMATCH time %0t halt expected 0 actual %0b", $time, halt);
            noteError(1);
        end
        assert (!dataWen) else begin
            $display("MISMATCH time %0t dataWen expected 0 actual %0b", $time, dataWen);
            noteError(1);
        end
        reportTest(1);

        cycles = 0;
        while (!halt && cycles < 400) begin
            nextCycle();
            cycles++;
        end
        if (!halt) begin
            $display("timeout: halt did not rise within 400 cycles");
            noteError(5);
        end
        for (int i = 0; i < 20; i++) begin
            assert (instrAddr == haltAddr) else begin
                $display("MISMATCH time %0t instrAddr expected 0x%08h actual 0x%08h", $time,
                         haltAddr, instrAddr);
                noteError(5);
            end
            assert (!dataWen) else begin
                $display("MISMATCH time %0t dataWen expected 0 actual %0b", $time, dataWen);
                noteError(5);
            end
            nextCycle();
        end
        assert (storeIdx == expAddr.size()) else begin
            $display("store count is wrong: %0d seen, %0d expected", storeIdx, expAddr.size());
            noteError(5);
        end
        for (int t = 2; t <= 4; t++) begin
            if (!testDone[t]) begin
                $display("test %0d %s never saw all of its stores", t, testName[t]);
                noteError(t);
                reportTest(t);
            end
        end
        reportTest(5);

        $display("tests 5, failed %0d, errors %0d", testsFailed, errCount);
        if (errCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+logic
+incdir+tb
logic/cpu_pkg.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/alu.sv
logic/next_pc.sv
logic/single_cycle_cpu.sv
tb/cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the cpu testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cpu_tb -f sources.f --Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcpu_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
